/* logic/pla_params.svh */
/*
 * constants of the PLA receive parser: XGMII characters, plane and MAC
 * table sizes, field widths and the slice framing rule
 */
`ifndef PLA_PARAMS_SVH
`define PLA_PARAMS_SVH

// xgmii characters
`define PLA_XGMII_START     8'hFB
`define PLA_XGMII_TERM      8'hFD
`define PLA_PREAMBLE_WORD   24'h555555
`define PLA_SFD_WORD        32'h5555_55D5

// planes and mac table
`define PLA_NUM             3
`define PLA_AIR_PER_PLANE   8
`define PLA_MAC_W           48

// field and counter widths
`define PLA_SLICE_ID_W      15
`define PLA_ERR_CNT_W       16
`define PLA_LEN_CNT_W       7

// tag word through terminate word inclusive
`define PLA_SLICE_WORDS     7'd66
// terminate in lane 1, data bytes in 31..16
`define PLA_SLICE_TERM_CTRL 4'b0011

`endif

/* logic/pla_pkg.sv */
/*
 * shared types of the PLA receive parser: MAC table entry, the frame view
 * from the delimiter, the selected plane and the slice tag word layout
 */
`include "pla_params.svh"

package pla_pkg;

    typedef enum logic [1:0] {IDLE = 2'd0, PRE = 2'd1, MAC = 2'd2, DATA = 2'd3} pla_state_e;

    typedef logic [`PLA_LEN_CNT_W-1:0] pla_len_cnt_t;

    typedef struct packed {
        logic [`PLA_MAC_W-1:0]                         rcu;
        logic [`PLA_AIR_PER_PLANE-1:0][`PLA_MAC_W-1:0] air;
    } pla_plane_mac_t;

    // first word after the source address
    typedef struct packed {
        logic                       req;
        logic [`PLA_SLICE_ID_W-1:0] slice_id;
        logic [15:0]                half;
    } pla_tag_t;

    typedef union packed {
        logic [31:0] raw;
        pla_tag_t    tag;
    } pla_tag_u;

    typedef struct packed {
        pla_state_e   state;
        pla_len_cnt_t cnt;
        logic [31:0]  data;
        logic [3:0]   ctrl;
        logic [31:0]  prev;
        logic [31:0]  prev2;
        logic [31:0]  prev3;
        logic         term;
        logic [3:0]   term_ctrl;
        logic         is_data;
    } xgmii_frame_t;

    typedef struct packed {
        logic       mac_ok;
        logic [1:0] plane;
        logic       checked;
    } pla_plane_sel_t;

endpackage

/* logic/xgmii_rx_delimiter.sv */
/*
 * XGMII receive delimiter: registers the input word, finds start, SFD and
 * terminate, runs the PLA frame FSM and counts the words of each frame
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module xgmii_rx_delimiter
    import pla_pkg::*;
(
    input  logic         I_pla_312m5_clk,
    input  logic         I_pla_rst,
    input  logic [31:0]  xgmii_rxd,
    input  logic [3:0]   xgmii_rxc,
    output xgmii_frame_t frame
);

    logic         start_hit;
    logic         sfd_hit;
    logic         ctrl_any;
    logic         term_hit;
    pla_state_e   state_nxt;
    pla_len_cnt_t cnt_nxt;

    pla_state_e   state_q;
    pla_len_cnt_t cnt_q;
    logic [3:0]   ctrl_q;
    logic         term_q;
    logic [3:0]   term_ctrl_q;
    logic         is_data_q;
    logic [31:0]  data_q;
    logic [31:0]  prev_q;
    logic [31:0]  prev2_q;
    logic [31:0]  prev3_q;

    assign start_hit = (xgmii_rxc == 4'b1000) &&
                       (xgmii_rxd == {`PLA_XGMII_START, `PLA_PREAMBLE_WORD});
    assign sfd_hit   = (xgmii_rxc == 4'b0000) && (xgmii_rxd == `PLA_SFD_WORD);
    assign ctrl_any  = |xgmii_rxc;

    // terminate lane is the highest control lane
    always_comb
    begin
        case (xgmii_rxc)
            4'b0001: term_hit = xgmii_rxd[7:0] == `PLA_XGMII_TERM;
            4'b0011: term_hit = xgmii_rxd[15:8] == `PLA_XGMII_TERM;
            4'b0111: term_hit = xgmii_rxd[23:16] == `PLA_XGMII_TERM;
            4'b1111: term_hit = xgmii_rxd[31:24] == `PLA_XGMII_TERM;
            default: term_hit = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // frame fsm, state labels the word now registered
    // --------------------------------------------------
    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            IDLE: state_nxt = start_hit ? PRE : IDLE;
            PRE:
            begin
                if (sfd_hit)
                    state_nxt = MAC;
                else
                    state_nxt = start_hit ? PRE : IDLE;
            end
            MAC:
            begin
                if (ctrl_any)
                    state_nxt = IDLE;
                else if (cnt_q == pla_len_cnt_t'(3))
                    state_nxt = DATA;
            end
            DATA:
            begin
                // leave once the last registered word carried control
                if (|ctrl_q)
                    state_nxt = start_hit ? PRE : IDLE;
            end
        endcase
    end

    always_comb
    begin
        case (state_nxt)
            MAC:     cnt_nxt = (state_q == MAC) ? cnt_q + 1'b1 : '0;
            DATA:
            begin
                if (state_q != DATA)
                    cnt_nxt = pla_len_cnt_t'(1);
                else
                    cnt_nxt = (&cnt_q) ? cnt_q : cnt_q + 1'b1;
            end
            default: cnt_nxt = '0;
        endcase
    end

    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst)
        begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            ctrl_q      <= 4'hf;
            term_q      <= 1'b0;
            term_ctrl_q <= 4'h0;
            is_data_q   <= 1'b0;
        end
        else
        begin
            state_q     <= state_nxt;
            cnt_q       <= cnt_nxt;
            ctrl_q      <= xgmii_rxc;
            term_q      <= term_hit;
            term_ctrl_q <= term_hit ? xgmii_rxc : 4'h0;
            is_data_q   <= ~ctrl_any;
        end
    end

    // delay line, last four words feed the address compare
    always_ff @(posedge I_pla_312m5_clk)
    begin
        data_q  <= xgmii_rxd;
        prev_q  <= data_q;
        prev2_q <= prev_q;
        prev3_q <= prev2_q;
    end

    assign frame = '{state: state_q, cnt: cnt_q, data: data_q, ctrl: ctrl_q,
                     prev: prev_q, prev2: prev2_q, prev3: prev3_q, term: term_q,
                     term_ctrl: term_ctrl_q, is_data: is_data_q};

endmodule

/* logic/pla_mac_match.sv */
/*
 * address match: compares DA and SA of each frame against the RCU and air
 * MACs of every plane and locks the highest matching plane
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module pla_mac_match
    import pla_pkg::*;
(
    input  logic                           I_pla_312m5_clk,
    input  logic                           I_pla_rst,
    input  xgmii_frame_t                   frame,
    input  pla_plane_mac_t [`PLA_NUM-1:0]  mac_cfg,
    output pla_plane_sel_t                 plane_sel
);

    logic [`PLA_MAC_W-1:0]                       da;
    logic [`PLA_MAC_W-1:0]                       sa;
    logic [`PLA_NUM-1:0]                         da_hit;
    logic [`PLA_NUM-1:0][`PLA_AIR_PER_PLANE-1:0] sa_hit;
    logic [`PLA_NUM-1:0]                         plane_hit;
    logic [1:0]                                  best;
    logic                                        enter_data;

    // tag word registered, addresses sit in the three words before it
    assign da = {frame.prev3, frame.prev2[31:16]};
    assign sa = {frame.prev2[15:0], frame.prev};

    assign enter_data = (frame.state == DATA) && (frame.cnt == pla_len_cnt_t'(1));

    generate
        for (genvar p = 0; p < `PLA_NUM; p++)
        begin : g_plane
            assign da_hit[p] = da == mac_cfg[p].rcu;
            for (genvar a = 0; a < `PLA_AIR_PER_PLANE; a++)
            begin : g_air
                assign sa_hit[p][a] = sa == mac_cfg[p].air[a];
            end
            assign plane_hit[p] = da_hit[p] && (|sa_hit[p]);
        end
    endgenerate

    // higher plane index wins
    always_comb
    begin
        best = 2'd0;
        for (int p = 0; p < `PLA_NUM; p++)
        begin
            if (plane_hit[p])
                best = 2'(p);
        end
    end

    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst)
        begin
            plane_sel <= '0;
        end
        else
        begin
            plane_sel.checked <= enter_data;
            if (enter_data)
            begin
                plane_sel.mac_ok <= |plane_hit;
                plane_sel.plane  <= best;
            end
        end
    end

endmodule

/* logic/pla_slice_check.sv */
/*
 * slice check: decodes the tag word, realigns payload halves into 32-bit
 * words, applies the length and terminate-lane rule per frame and keeps
 * the length and MAC error counters
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module pla_slice_check
    import pla_pkg::*;
(
    input  logic                        I_pla_312m5_clk,
    input  logic                        I_pla_rst,
    input  xgmii_frame_t                frame,
    input  pla_plane_sel_t              plane_sel,
    input  logic                        cnt_clear,
    output logic [`PLA_SLICE_ID_W-1:0]  slice_id,
    output logic [31:0]                 payload,
    output logic                        payload_en,
    output logic [`PLA_NUM-1:0]         check_ok,
    output logic [`PLA_ERR_CNT_W-1:0]   len_err_cnt,
    output logic [`PLA_ERR_CNT_W-1:0]   mac_err_cnt
);

    pla_tag_u    cur_w;
    logic        tag_now;
    logic        end_now;
    logic        len_ok;
    logic        req_q;
    logic        slice_ok_q;
    logic        len_err_q;
    logic        payload_en_q;
    logic [31:0] payload_q;

    assign cur_w   = frame.data;
    assign tag_now = (frame.state == DATA) && frame.is_data && (frame.cnt == pla_len_cnt_t'(1));
    assign end_now = (frame.state == DATA) && !frame.is_data;
    assign len_ok  = (frame.cnt == `PLA_SLICE_WORDS) && frame.term &&
                     (frame.term_ctrl == `PLA_SLICE_TERM_CTRL);

    // --------------------------------------------------
    // first stage: tag decode and end-of-frame verdict
    // --------------------------------------------------
    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst)
        begin
            req_q        <= 1'b0;
            slice_id     <= '0;
            slice_ok_q   <= 1'b0;
            len_err_q    <= 1'b0;
            payload_en_q <= 1'b0;
        end
        else
        begin
            if (tag_now)
            begin
                req_q    <= cur_w.tag.req;
                slice_id <= cur_w.tag.req ? '0 : cur_w.tag.slice_id;
            end
            slice_ok_q   <= end_now && plane_sel.mac_ok && !req_q && len_ok;
            len_err_q    <= end_now && plane_sel.mac_ok && !req_q && !len_ok;
            payload_en_q <= (frame.state == DATA) && frame.is_data &&
                            (frame.cnt > pla_len_cnt_t'(1));
        end
    end

    // low half of the previous word leads
    always_ff @(posedge I_pla_312m5_clk)
    begin
        payload_q <= {frame.prev[15:0], cur_w.raw[31:16]};
        payload   <= payload_q;
    end

    // --------------------------------------------------
    // second stage: outputs and counters
    // --------------------------------------------------
    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst)
        begin
            payload_en <= 1'b0;
            check_ok   <= '0;
        end
        else
        begin
            payload_en <= payload_en_q;
            check_ok   <= slice_ok_q ? ({{(`PLA_NUM-1){1'b0}}, 1'b1} << plane_sel.plane) : '0;
        end
    end

    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst || cnt_clear)
        begin
            len_err_cnt <= '0;
            mac_err_cnt <= '0;
        end
        else
        begin
            if (len_err_q)
                len_err_cnt <= len_err_cnt + 1'b1;
            // frame reached data with no plane matching
            if (plane_sel.checked && !plane_sel.mac_ok)
                mac_err_cnt <= mac_err_cnt + 1'b1;
        end
    end

endmodule

/* logic/pla_wr_resp_track.sv */
/*
 * write response tracking: each plane keeps the id of its last accepted
 * slice and publishes it on a rising edge of its write response
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module pla_wr_resp_track
(
    input  logic                                        I_pla_312m5_clk,
    input  logic                                        I_pla_rst,
    input  logic [`PLA_NUM-1:0]                         check_ok,
    input  logic [`PLA_SLICE_ID_W-1:0]                  slice_id,
    input  logic [`PLA_NUM-1:0]                         wr_resp,
    output logic [`PLA_NUM-1:0][`PLA_SLICE_ID_W-1:0]    new_id,
    output logic [`PLA_NUM-1:0]                         new_id_valid
);

    logic [`PLA_NUM-1:0]                      wr_q;
    logic [`PLA_NUM-1:0]                      wr_rise;
    logic [`PLA_NUM-1:0][`PLA_SLICE_ID_W-1:0] last_id;

    assign wr_rise = wr_resp & ~wr_q;

    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (I_pla_rst)
        begin
            wr_q         <= '0;
            last_id      <= '0;
            new_id       <= '0;
            new_id_valid <= '0;
        end
        else
        begin
            wr_q         <= wr_resp;
            new_id_valid <= wr_rise;
            for (int p = 0; p < `PLA_NUM; p++)
            begin
                if (check_ok[p])
                    last_id[p] <= slice_id;
                if (wr_rise[p])
                    new_id[p] <= last_id[p];
            end
        end
    end

endmodule

/* logic/pla_backward_parser.sv */
/*
 * PLA receive-side slice parser top: XGMII delimiter, address match,
 * slice check and write response tracking
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module pla_backward_parser
    import pla_pkg::*;
(
    input  logic                                        I_pla_312m5_clk,
    input  logic                                        I_pla_rst,
    input  logic [31:0]                                 xgmii_rxd,
    input  logic [3:0]                                  xgmii_rxc,
    input  pla_plane_mac_t [`PLA_NUM-1:0]               mac_cfg,
    input  logic [`PLA_NUM-1:0]                         wr_resp,
    input  logic                                        cnt_clear,
    output logic [1:0]                                  xgmii_pla_num,
    output logic [`PLA_SLICE_ID_W-1:0]                  slice_id,
    output logic [31:0]                                 payload,
    output logic                                        payload_en,
    output logic [`PLA_NUM-1:0]                         check_ok,
    output logic [`PLA_NUM-1:0][`PLA_SLICE_ID_W-1:0]    new_id,
    output logic [`PLA_NUM-1:0]                         new_id_valid,
    output logic [`PLA_ERR_CNT_W-1:0]                   len_err_cnt,
    output logic [`PLA_ERR_CNT_W-1:0]                   mac_err_cnt
);

    xgmii_frame_t   frame;
    pla_plane_sel_t plane_sel;

    assign xgmii_pla_num = plane_sel.plane;

    xgmii_rx_delimiter u_delimiter (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .xgmii_rxd       (xgmii_rxd),
        .xgmii_rxc       (xgmii_rxc),
        .frame           (frame)
    );

    pla_mac_match u_mac_match (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .frame           (frame),
        .mac_cfg         (mac_cfg),
        .plane_sel       (plane_sel)
    );

    pla_slice_check u_slice_check (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .frame           (frame),
        .plane_sel       (plane_sel),
        .cnt_clear       (cnt_clear),
        .slice_id        (slice_id),
        .payload         (payload),
        .payload_en      (payload_en),
        .check_ok        (check_ok),
        .len_err_cnt     (len_err_cnt),
        .mac_err_cnt     (mac_err_cnt)
    );

    pla_wr_resp_track u_wr_resp_track (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .check_ok        (check_ok),
        .slice_id        (slice_id),
        .wr_resp         (wr_resp),
        .new_id          (new_id),
        .new_id_valid    (new_id_valid)
    );

endmodule

/* testbench/pla_parser_chk.sv */
/*
 * concurrent checks on the parser strobes, bound into the top level:
 * one plane per acceptance, single-cycle pulses, quiet outputs in reset
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module pla_parser_chk
(
    input  logic                   I_pla_312m5_clk,
    input  logic                   I_pla_rst,
    input  logic [`PLA_NUM-1:0]    check_ok,
    input  logic [`PLA_NUM-1:0]    new_id_valid,
    input  logic                   payload_en
);

    a_ok_onehot: assert property (@(posedge I_pla_312m5_clk) disable iff (I_pla_rst)
        $onehot0(check_ok))
        else $error("check_ok set on more than one plane");

    a_ok_pulse: assert property (@(posedge I_pla_312m5_clk) disable iff (I_pla_rst)
        (|check_ok) |=> (check_ok == '0))
        else $error("check_ok held longer than one cycle");

    a_nid_pulse: assert property (@(posedge I_pla_312m5_clk) disable iff (I_pla_rst)
        (|new_id_valid) |=> (new_id_valid == '0))
        else $error("new_id_valid held longer than one cycle");

    // registered strobes are cleared by every reset cycle
    a_reset_quiet: assert property (@(posedge I_pla_312m5_clk)
        I_pla_rst |=> ((check_ok == '0) && (new_id_valid == '0) && !payload_en))
        else $error("output strobe active during reset");

endmodule

bind pla_backward_parser pla_parser_chk u_chk (
    .I_pla_312m5_clk (I_pla_312m5_clk),
    .I_pla_rst       (I_pla_rst),
    .check_ok        (check_ok),
    .new_id_valid    (new_id_valid),
    .payload_en      (payload_en)
);

/* testbench/tb_pla_parser.sv */
/*
 * testbench for the PLA receive parser: replays frame, write response and
 * clear commands from the stim file and scores payload, pulses and counters
 */
`timescale 1ns/100ps
`include "pla_params.svh"

module tb_pla_parser
    import pla_pkg::*;
();

    typedef struct packed {
        logic [1:0]                 kind;
        logic [1:0]                 plane;
        logic [2:0]                 air;
        logic                       req;
        logic [`PLA_SLICE_ID_W-1:0] id;
        logic [6:0]                 wc;
        logic [3:0]                 mask;
        logic [1:0]                 corrupt;
    } stim_t;

    typedef struct packed {
        logic [31:0] cyc;
        logic [1:0]  plane;
        logic [31:0] val;
    } exp_evt_t;

    localparam logic [31:0] idle_word = 32'h0707_0707;

    logic                                       I_pla_312m5_clk;
    logic                                       I_pla_rst;
    logic [31:0]                                xgmii_rxd;
    logic [3:0]                                 xgmii_rxc;
    pla_plane_mac_t [`PLA_NUM-1:0]              mac_cfg;
    logic [`PLA_NUM-1:0]                        wr_resp;
    logic                                       cnt_clear;
    logic [1:0]                                 xgmii_pla_num;
    logic [`PLA_SLICE_ID_W-1:0]                 slice_id;
    logic [31:0]                                payload;
    logic                                       payload_en;
    logic [`PLA_NUM-1:0]                        check_ok;
    logic [`PLA_NUM-1:0][`PLA_SLICE_ID_W-1:0]   new_id;
    logic [`PLA_NUM-1:0]                        new_id_valid;
    logic [`PLA_ERR_CNT_W-1:0]                  len_err_cnt;
    logic [`PLA_ERR_CNT_W-1:0]                  mac_err_cnt;

    logic [31:0]                lcg_state = 32'hfc65;
    logic [`PLA_NUM-1:0]        wr_drv;
    logic                       clr_drv;
    logic [`PLA_SLICE_ID_W-1:0] last_id [`PLA_NUM];
    logic [`PLA_ERR_CNT_W-1:0]  exp_len;
    logic [`PLA_ERR_CNT_W-1:0]  exp_mac;
    stim_t                      stim_q [$];
    exp_evt_t                   exp_pay [$];
    exp_evt_t                   exp_ok [$];
    exp_evt_t                   exp_nid [$];
    int                         cyc_now;
    int                         wd_cyc;
    int                         wd_limit = 10000;
    int                         checks;
    int                         errors;

    pla_backward_parser UUT (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .xgmii_rxd       (xgmii_rxd),
        .xgmii_rxc       (xgmii_rxc),
        .mac_cfg         (mac_cfg),
        .wr_resp         (wr_resp),
        .cnt_clear       (cnt_clear),
        .xgmii_pla_num   (xgmii_pla_num),
        .slice_id        (slice_id),
        .payload         (payload),
        .payload_en      (payload_en),
        .check_ok        (check_ok),
        .new_id          (new_id),
        .new_id_valid    (new_id_valid),
        .len_err_cnt     (len_err_cnt),
        .mac_err_cnt     (mac_err_cnt)
    );

    initial
    begin
        I_pla_312m5_clk = 1'b0;
        forever #4 I_pla_312m5_clk = ~I_pla_312m5_clk;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    always @(posedge I_pla_312m5_clk)
    begin
        wd_cyc++;
        if (wd_cyc > wd_limit)
        begin
            $display("timeout: run did not finish");
            errors++;
            finish_run();
        end
    end

    // --------------------------------------------------
    // sampling of the previous edge, then new inputs
    // --------------------------------------------------
    task automatic observe();
        exp_evt_t e;
        if (payload_en)
        begin
            checks++;
            if (exp_pay.size() == 0)
            begin
                $display("error %0t ns: payload_en with no word expected", $time);
                errors++;
            end
            else
            begin
                e = exp_pay.pop_front();
                if (payload !== e.val || cyc_now != int'(e.cyc))
                begin
                    $display("error %0t ns: payload %h, expected %h in cycle %0d",
                             $time, payload, e.val, e.cyc);
                    errors++;
                end
            end
        end
        if (check_ok != '0)
        begin
            checks++;
            if (exp_ok.size() == 0)
            begin
                $display("error %0t ns: check_ok %b with no slice expected", $time, check_ok);
                errors++;
            end
            else
            begin
                e = exp_ok.pop_front();
                if (check_ok != (3'b001 << e.plane) || xgmii_pla_num != e.plane ||
                    slice_id != e.val[`PLA_SLICE_ID_W-1:0] || cyc_now != int'(e.cyc))
                begin
                    $display("error %0t ns: check_ok %b plane %0d id %h, expected %0d id %h",
                             $time, check_ok, xgmii_pla_num, slice_id, e.plane,
                             e.val[`PLA_SLICE_ID_W-1:0]);
                    errors++;
                end
            end
        end
        if (new_id_valid != '0)
        begin
            checks++;
            if (exp_nid.size() == 0)
            begin
                $display("error %0t ns: new_id_valid %b not expected", $time, new_id_valid);
                errors++;
            end
            else
            begin
                e = exp_nid.pop_front();
                if (new_id_valid != (3'b001 << e.plane) ||
                    new_id[e.plane] != e.val[`PLA_SLICE_ID_W-1:0] || cyc_now != int'(e.cyc))
                begin
                    $display("error %0t ns: new id %h on %b, expected %h on plane %0d",
                             $time, new_id[e.plane], new_id_valid, e.val, e.plane);
                    errors++;
                end
            end
        end
    endtask

    task automatic tick(input logic [31:0] d, input logic [3:0] c);
        @(negedge I_pla_312m5_clk);
        cyc_now++;
        observe();
        xgmii_rxd = d;
        xgmii_rxc = c;
        wr_resp   = wr_drv;
        cnt_clear = clr_drv;
    endtask

    task automatic settle_and_check();
        repeat (16) tick(idle_word, 4'hf);
        checks += 2;
        if (len_err_cnt !== exp_len || mac_err_cnt !== exp_mac)
        begin
            $display("error %0t ns: counters len %0d mac %0d, expected len %0d mac %0d",
                     $time, len_err_cnt, mac_err_cnt, exp_len, exp_mac);
            errors++;
        end
        if (exp_pay.size() + exp_ok.size() + exp_nid.size() != 0)
        begin
            $display("error %0t ns: missing %0d payload, %0d check_ok, %0d new id", $time,
                     exp_pay.size(), exp_ok.size(), exp_nid.size());
            errors++;
            exp_pay.delete();
            exp_ok.delete();
            exp_nid.delete();
        end
    endtask

    // low byte holds the entry index, so every MAC differs from all others
    task automatic fill_mac_table();
        logic [31:0] r;
        logic [31:0] q;
        for (int p = 0; p < `PLA_NUM; p++)
        begin
            r = rand32();
            q = rand32();
            mac_cfg[p].rcu = {r, q[7:0], 8'(p * 9)};
            for (int a = 0; a < `PLA_AIR_PER_PLANE; a++)
            begin
                r = rand32();
                q = rand32();
                mac_cfg[p].air[a] = {r, q[7:0], 8'(p * 9 + a + 1)};
            end
        end
    endtask

    // --------------------------------------------------
    // frame generation and expected results
    // --------------------------------------------------
    task automatic send_frame(input stim_t s);
        logic [`PLA_MAC_W-1:0] da;
        logic [`PLA_MAC_W-1:0] sa;
        logic [31:0]           prev_w;
        logic [31:0]           w;
        exp_evt_t              e;
        int                    hi;
        da = mac_cfg[s.plane].rcu;
        sa = mac_cfg[s.plane].air[s.air];
        // one flipped top bit misses every table entry
        if (s.corrupt == 2'd1)
            da[47] = ~da[47];
        if (s.corrupt == 2'd2)
            sa[47] = ~sa[47];
        tick({`PLA_XGMII_START, `PLA_PREAMBLE_WORD}, 4'b1000);
        tick(`PLA_SFD_WORD, 4'h0);
        tick(da[47:16], 4'h0);
        tick({da[15:0], sa[47:32]}, 4'h0);
        tick(sa[31:0], 4'h0);
        w = rand32();
        prev_w = {s.req, s.id, w[15:0]};
        tick(prev_w, 4'h0);
        for (int k = 0; k < int'(s.wc) - 2; k++)
        begin
            w = rand32();
            tick(w, 4'h0);
            e = '{cyc: 32'(cyc_now + 3), plane: s.plane, val: {prev_w[15:0], w[31:16]}};
            exp_pay.push_back(e);
            prev_w = w;
        end
        w = rand32();
        hi = 0;
        for (int i = 0; i < 4; i++)
        begin
            if (s.mask[i])
            begin
                w[8*i +: 8] = 8'h07;
                hi = i;
            end
        end
        w[8*hi +: 8] = `PLA_XGMII_TERM;
        tick(w, s.mask);
        if (s.corrupt != 2'd0)
            exp_mac++;
        else if (!s.req)
        begin
            if (s.wc == `PLA_SLICE_WORDS && s.mask == `PLA_SLICE_TERM_CTRL)
            begin
                e = '{cyc: 32'(cyc_now + 3), plane: s.plane, val: 32'(s.id)};
                exp_ok.push_back(e);
                last_id[s.plane] = s.id;
            end
            else
                exp_len++;
        end
    endtask

    task automatic pulse_wr_resp(input logic [1:0] plane);
        exp_evt_t e;
        wr_drv[plane] = 1'b1;
        tick(idle_word, 4'hf);
        e = '{cyc: 32'(cyc_now + 1), plane: plane, val: 32'(last_id[plane])};
        exp_nid.push_back(e);
        wr_drv[plane] = 1'b0;
    endtask

    task automatic clear_counters();
        clr_drv = 1'b1;
        tick(idle_word, 4'hf);
        clr_drv = 1'b0;
        exp_len = '0;
        exp_mac = '0;
    endtask

    task automatic load_stim(output logic ok);
        int           fd;
        int           code;
        int           pl;
        int           ai;
        int           rq;
        int           id;
        int           wc;
        int           mk;
        int           co;
        int           total;
        logic [63:0]  cmd;
        logic [799:0] junk;
        stim_t        s;
        total = 0;
        code = 0;
        fd = $fopen("testbench/pla_frames_stim.txt", "r");
        ok = fd != 0;
        if (ok)
        begin
            while (code != -1)
            begin
                s = '0;
                code = $fscanf(fd, "%s", cmd);
                if (code == 1 && cmd == "frame")
                begin
                    code = $fscanf(fd, "%d %d %d %h %d %b %d", pl, ai, rq, id, wc, mk, co);
                    s = '{kind: 2'd0, plane: 2'(pl), air: 3'(ai), req: 1'(rq),
                          id: 15'(id), wc: 7'(wc), mask: 4'(mk), corrupt: 2'(co)};
                    stim_q.push_back(s);
                    total += 5 + wc;
                end
                else if (code == 1 && cmd == "wr")
                begin
                    code = $fscanf(fd, "%d", pl);
                    s.kind = 2'd1;
                    s.plane = 2'(pl);
                    stim_q.push_back(s);
                end
                else if (code == 1 && cmd == "clr")
                begin
                    s.kind = 2'd2;
                    stim_q.push_back(s);
                end
                else if (code == 1)
                    code = $fgets(junk, fd);
            end
            $fclose(fd);
            wd_limit = total + 16 * stim_q.size() + 200;
        end
    endtask

    initial
    begin
        logic ok;
        I_pla_rst = 1'b1;
        xgmii_rxd = idle_word;
        xgmii_rxc = 4'hf;
        wr_resp   = '0;
        cnt_clear = 1'b0;
        mac_cfg   = '0;
        wr_drv    = '0;
        clr_drv   = 1'b0;
        exp_len   = '0;
        exp_mac   = '0;
        for (int p = 0; p < `PLA_NUM; p++)
            last_id[p] = '0;
        fill_mac_table();
        load_stim(ok);
        repeat (2) @(negedge I_pla_312m5_clk);
        I_pla_rst = 1'b0;
        if (!ok)
        begin
            $display("could not open the stimulus file testbench/pla_frames_stim.txt");
            errors++;
            finish_run();
        end
        else
        begin
            repeat (4) tick(idle_word, 4'hf);
            foreach (stim_q[i])
            begin
                case (stim_q[i].kind)
                    2'd0:    send_frame(stim_q[i]);
                    2'd1:    pulse_wr_resp(stim_q[i].plane);
                    default: clear_counters();
                endcase
                settle_and_check();
            end
            finish_run();
        end
    end

endmodule

/* testbench/pla_frames_stim.txt */
# frame plane air req slice_id(hex) words(tag..terminate) term_mask corrupt(0 none 1 DA 2 SA)
# wr plane | clr
wr 0
frame 0 3 0 0101 66 0011 0
frame 1 7 0 0202 66 0011 0
frame 2 0 0 7abc 66 0011 0
wr 0
wr 1
wr 2
# length and lane errors, then requests
frame 1 2 0 0303 65 0011 0
frame 2 5 0 0404 66 0111 0
frame 0 1 1 0505 66 0011 0
frame 0 6 1 0515 12 0001 0
# address errors
frame 0 4 0 0606 66 0011 1
frame 2 6 0 0707 66 0011 2
clr
frame 1 0 0 1234 66 0011 0
wr 1
frame 0 0 0 0808 70 1111 0
frame 1 1 1 0909 10 0011 2
frame 2 3 0 1fff 66 0011 0
wr 2

/* tb.f */
+incdir+logic
logic/pla_pkg.sv
logic/xgmii_rx_delimiter.sv
logic/pla_mac_match.sv
logic/pla_slice_check.sv
logic/pla_wr_resp_track.sv
logic/pla_backward_parser.sv
testbench/pla_parser_chk.sv
testbench/tb_pla_parser.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_pla_parser
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pla_parser)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
